// ==== common/cache_pkg.sv ====
// cache package
// address split, line geometry and the lookup / far-memory encodings
`default_nettype none

package cache_pkg;

  // ============================================================
  // address layout {tag, set, offset}
  // ============================================================
  localparam int ADDR_WIDTH     = 20;
  localparam int OFFSET_WIDTH   = 4;     // 16-byte line
  localparam int SET_WIDTH      = 4;     // 16 sets
  localparam int TAG_WIDTH      = ADDR_WIDTH - SET_WIDTH - OFFSET_WIDTH;
  localparam int NUM_SETS       = 2 ** SET_WIDTH;

  // line geometry
  localparam int WORD_WIDTH     = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_SEL_WIDTH = 2;     // taken from offset[3:2]
  localparam int TQ_ID_WIDTH    = 4;

  typedef logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] cache_line_t;   // 128b line

  // lookup opcode
  typedef enum logic [1:0] {
    RD_LU   = 2'd0,
    WR_LU   = 2'd1,
    FILL_LU = 2'd2
  } lu_op_t;

  // lookup result, NO_RSP only while the q3 slot is empty
  typedef enum logic [1:0] {
    NO_RSP = 2'd0,
    HIT    = 2'd1,
    MISS   = 2'd2,
    FILL   = 2'd3
  } lu_result_t;

  typedef enum logic {
    FILL_REQ_OP    = 1'b0,   // line fetch on rd/wr miss
    DIRTY_EVICT_OP = 1'b1    // write back of a modified victim
  } fm_opcode_t;

endpackage

`default_nettype wire

// ==== hdl/sync_ram.sv ====
// synchronous 1R1W storage array
// registered read port, whole array cleared by reset
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
  parameter int  DEPTH   = 16,
  parameter type entry_t = logic [31:0]
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  var entry_t               wr_data,
  output entry_t                   rd_data
);

  entry_t mem [DEPTH];

  // read sees the old entry when the same location is written this cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;   // every entry back to zero
      end
      rd_data <= '0;
    end else begin
      if (wr_en) begin
        mem[wr_addr] <= wr_data;
      end
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== cache/cache_victim_sel.sv ====
// fill victim selector
// first free way, else first way with a clear MRU bit; flags dirty evicts
`timescale 1ns/1ps
`default_nettype none

module cache_victim_sel #(
  parameter int NUM_WAYS = 4
) (
  input  logic                        is_fill,
  input  logic [NUM_WAYS-1:0]         way_valid,
  input  logic [NUM_WAYS-1:0]         way_mru,
  input  logic [NUM_WAYS-1:0]         way_modified,
  output logic [NUM_WAYS-1:0]         victim,       // one-hot, zero if no fill
  output logic [$clog2(NUM_WAYS)-1:0] victim_enc,
  output logic                        dirty_evict
);

  logic [NUM_WAYS-1:0] cand;   // ways eligible for replacement

  always_comb begin
    cand       = (|(~way_valid)) ? ~way_valid : ~way_mru;   // free ways win
    victim     = '0;
    victim_enc = '0;
    // scan from the top so the lowest candidate is the one that sticks
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (cand[w]) begin
        victim     = '0;
        victim[w]  = 1'b1;
        victim_enc = $clog2(NUM_WAYS)'(w);
      end
    end
    if (!is_fill) begin
      victim     = '0;
      victim_enc = '0;
    end
  end

  // only a valid modified line has to go back to far memory
  assign dirty_evict = |(victim & way_valid & way_modified);

  // the MRU flip in q2 never leaves a full set with every MRU bit set
  always_comb begin
    if (is_fill) begin
      fill_victim_a: assert final (|victim)
        else $error("fill found no victim way");
    end
  end

endmodule

`default_nettype wire

// ==== cache/cache_tag_stage.sv ====
// cache tag stage
// q1 tag array read, q2 forwarding, tag compare, MRU / valid / modified update
// and tag write-back, registered hand-off to q3
`timescale 1ns/1ps
`default_nettype none

module cache_tag_stage
  import cache_pkg::*;
#(
  parameter int  NUM_WAYS    = 4,
  localparam int WAY_WIDTH   = $clog2(NUM_WAYS),
  localparam int ENTRY_WIDTH = NUM_WAYS * (TAG_WIDTH + 3)   // {tags, valid, mod, mru}
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // lookup request, q1
  input  logic                          req_valid,
  input  var lu_op_t                    req_op,
  input  logic [ADDR_WIDTH-1:0]         req_address,
  input  logic [TQ_ID_WIDTH-1:0]        req_tq_id,
  input  logic [WORD_WIDTH-1:0]         req_data,
  input  var cache_line_t               req_cl_data,
  input  logic                          req_fill_modified,
  // tag array
  output logic [SET_WIDTH-1:0]          set_rd_addr,
  input  logic [ENTRY_WIDTH-1:0]        set_rd_entry,
  output logic                          set_wr_en,
  output logic [SET_WIDTH-1:0]          set_wr_addr,
  output logic [ENTRY_WIDTH-1:0]        set_wr_entry,
  // data array read, q2
  output logic [SET_WIDTH+WAY_WIDTH-1:0] cl_rd_addr,
  // q3 pipe
  output logic                          q3_valid,
  output lu_op_t                        q3_op,
  output logic [TAG_WIDTH-1:0]          q3_tag,
  output logic [SET_WIDTH-1:0]          q3_set,
  output logic [OFFSET_WIDTH-1:0]       q3_offset,
  output logic [TQ_ID_WIDTH-1:0]        q3_tq_id,
  output logic [WORD_WIDTH-1:0]         q3_word,
  output cache_line_t                   q3_line,
  output logic                          q3_hit,
  output logic [SET_WIDTH+WAY_WIDTH-1:0] q3_data_addr,
  output logic                          q3_dirty_evict,
  output logic [TAG_WIDTH-1:0]          q3_old_tag
);

  logic                              q2_valid;
  lu_op_t                            q2_op;
  logic [TAG_WIDTH-1:0]              q2_tag;
  logic [SET_WIDTH-1:0]              q2_set;
  logic [OFFSET_WIDTH-1:0]           q2_offset;
  logic [TQ_ID_WIDTH-1:0]            q2_tq_id;
  logic [WORD_WIDTH-1:0]             q2_word;
  cache_line_t                       q2_line;
  logic                              q2_fill_mod;
  logic [ENTRY_WIDTH-1:0]            fwd_entry;   // tag write of the lookup now in q3
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] cur_tags, new_tags;
  logic [NUM_WAYS-1:0]               cur_valid, cur_mod, cur_mru;
  logic [NUM_WAYS-1:0]               new_valid, new_mod, new_mru;
  logic [NUM_WAYS-1:0]               hit_vec, victim, touched;
  logic [WAY_WIDTH-1:0]              hit_enc, victim_enc;
  logic                              hit, is_fill, dirty_evict;

  // ============================================================
  // q1  tag read and request capture
  // ============================================================
  assign set_rd_addr = req_address[OFFSET_WIDTH +: SET_WIDTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q2_valid <= 1'b0;
    end else begin
      q2_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    q2_op       <= req_op;
    q2_tag      <= req_address[ADDR_WIDTH-1 -: TAG_WIDTH];
    q2_set      <= req_address[OFFSET_WIDTH +: SET_WIDTH];
    q2_offset   <= req_address[OFFSET_WIDTH-1:0];
    q2_tq_id    <= req_tq_id;
    q2_word     <= req_data;
    q2_line     <= req_cl_data;
    q2_fill_mod <= req_fill_modified;
  end

  // ============================================================
  // q2  forwarding, compare, victim, set update
  // ============================================================
  // back-to-back same set: the array still holds the state before q3's write
  assign {cur_tags, cur_valid, cur_mod, cur_mru} =
    (q3_valid && (q3_set == q2_set)) ? fwd_entry : set_rd_entry;

  always_comb begin
    hit_enc = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = q2_valid && cur_valid[w] && (cur_tags[w] == q2_tag);
      if (hit_vec[w]) begin
        hit_enc = WAY_WIDTH'(w);
      end
    end
  end
  assign hit     = |hit_vec;
  assign is_fill = q2_valid && (q2_op == FILL_LU);

  cache_victim_sel #(.NUM_WAYS(NUM_WAYS)) u_victim_sel (
    .is_fill      (is_fill),
    .way_valid    (cur_valid),
    .way_mru      (cur_mru),
    .way_modified (cur_mod),
    .victim       (victim),
    .victim_enc   (victim_enc),
    .dirty_evict  (dirty_evict)
  );

  always_comb begin
    new_tags  = cur_tags;   // default keeps the set as read
    new_valid = cur_valid;
    new_mod   = cur_mod;
    new_mru   = cur_mru;
    touched   = '0;         // stays zero on a miss
    if (q2_valid && hit && (q2_op != FILL_LU)) begin
      touched = hit_vec;
      new_mru = cur_mru | hit_vec;
      if (q2_op == WR_LU) begin
        new_mod = cur_mod | hit_vec;   // write hit dirties the line
      end
    end
    if (is_fill) begin
      touched              = victim;
      new_mru              = cur_mru | victim;
      new_valid            = cur_valid | victim;
      new_tags[victim_enc] = q2_tag;
      new_mod              = q2_fill_mod ? (cur_mod | victim) : (cur_mod & ~victim);
    end
    // pseudo-LRU wrap, restart from the way just used
    if ((|touched) && (&new_mru)) begin
      new_mru = touched;
    end
  end

  assign set_wr_en    = q2_valid;   // written back on every lookup
  assign set_wr_addr  = q2_set;
  assign set_wr_entry = {new_tags, new_valid, new_mod, new_mru};
  assign cl_rd_addr   = {q2_set, is_fill ? victim_enc : hit_enc};

  // ============================================================
  // q2 -> q3 hand-off
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q3_valid <= 1'b0;
    end else begin
      q3_valid <= q2_valid;
    end
  end

  always_ff @(posedge clk) begin
    q3_op          <= q2_op;
    q3_tag         <= q2_tag;
    q3_set         <= q2_set;
    q3_offset      <= q2_offset;
    q3_tq_id       <= q2_tq_id;
    q3_word        <= q2_word;
    q3_line        <= q2_line;
    q3_hit         <= hit;
    q3_data_addr   <= cl_rd_addr;
    q3_dirty_evict <= dirty_evict;
    q3_old_tag     <= cur_tags[victim_enc];   // evict address for q3
    fwd_entry      <= set_wr_entry;
  end

  // forwarding plus the victim choice keep each tag at most once per set
  hit_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== cache/cache_data_stage.sv ====
// cache data stage
// q3 data forwarding, write merge and data write, lookup response
// and far-memory fill / dirty evict request
`timescale 1ns/1ps
`default_nettype none

module cache_data_stage
  import cache_pkg::*;
#(
  parameter int  NUM_WAYS      = 4,
  localparam int CL_ADDR_WIDTH = SET_WIDTH + $clog2(NUM_WAYS)
) (
  input  logic                     clk,
  input  logic                     rst_n,
  // q3 pipe
  input  logic                     q3_valid,
  input  var lu_op_t               q3_op,
  input  logic [TAG_WIDTH-1:0]     q3_tag,
  input  logic [SET_WIDTH-1:0]     q3_set,
  input  logic [OFFSET_WIDTH-1:0]  q3_offset,
  input  logic [TQ_ID_WIDTH-1:0]   q3_tq_id,
  input  logic [WORD_WIDTH-1:0]    q3_word,
  input  var cache_line_t          q3_line,
  input  logic                     q3_hit,
  input  logic [CL_ADDR_WIDTH-1:0] q3_data_addr,
  input  logic                     q3_dirty_evict,
  input  logic [TAG_WIDTH-1:0]     q3_old_tag,
  // data array
  input  var cache_line_t          cl_rd_data,
  output logic                     cl_wr_en,
  output logic [CL_ADDR_WIDTH-1:0] cl_wr_addr,
  output cache_line_t              cl_wr_data,
  // lookup response
  output logic                     rsp_valid,
  output lu_op_t                   rsp_op,
  output lu_result_t               rsp_result,
  output logic [TQ_ID_WIDTH-1:0]   rsp_tq_id,
  output logic [ADDR_WIDTH-1:0]    rsp_address,
  output cache_line_t              rsp_cl_data,
  // far memory
  output logic                     fm_valid,
  output fm_opcode_t               fm_opcode,
  output logic [ADDR_WIDTH-1:0]    fm_address,
  output logic [TQ_ID_WIDTH-1:0]   fm_tq_id,
  output cache_line_t              fm_data
);

  logic                      q4_wr_en;    // last data write, for forwarding
  logic [CL_ADDR_WIDTH-1:0]  q4_wr_addr;
  cache_line_t               q4_wr_data;
  cache_line_t               line, merged;
  logic [WORD_SEL_WIDTH-1:0] word_sel;
  logic                      is_fill, wr_hit, rd_hit, lu_miss;

  assign word_sel = q3_offset[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
  assign is_fill  = q3_valid && (q3_op == FILL_LU);
  assign wr_hit   = q3_valid && (q3_op == WR_LU) && q3_hit;
  assign rd_hit   = q3_valid && (q3_op == RD_LU) && q3_hit;
  assign lu_miss  = q3_valid && (q3_op != FILL_LU) && !q3_hit;

  // ============================================================
  // data forwarding and write
  // ============================================================
  // array read misses a write issued one cycle earlier to the same line
  assign line = (q4_wr_en && (q4_wr_addr == q3_data_addr)) ? q4_wr_data : cl_rd_data;

  always_comb begin
    merged           = line;
    merged[word_sel] = q3_word;   // write hit overrides a single word
  end

  assign cl_wr_en   = wr_hit || is_fill;
  assign cl_wr_addr = q3_data_addr;
  assign cl_wr_data = is_fill ? q3_line : merged;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q4_wr_en <= 1'b0;
    end else begin
      q4_wr_en <= cl_wr_en;
    end
  end

  always_ff @(posedge clk) begin
    q4_wr_addr <= cl_wr_addr;
    q4_wr_data <= cl_wr_data;
  end

  // ============================================================
  // response and far-memory request
  // ============================================================
  assign rsp_valid   = q3_valid;
  assign rsp_op      = q3_op;
  assign rsp_tq_id   = q3_tq_id;
  assign rsp_address = {q3_tag, q3_set, q3_offset};
  assign rsp_cl_data = is_fill ? q3_line : (rd_hit ? line : '0);
  assign rsp_result  = !q3_valid ? NO_RSP :
                       is_fill   ? FILL   :
                       q3_hit    ? HIT    : MISS;

  always_comb begin
    fm_valid   = lu_miss;        // rd/wr miss asks for the line
    fm_opcode  = FILL_REQ_OP;
    fm_address = rsp_address;
    fm_data    = '0;
    if (is_fill && q3_dirty_evict) begin
      fm_valid   = 1'b1;
      fm_opcode  = DIRTY_EVICT_OP;
      fm_address = {q3_old_tag, q3_set, {OFFSET_WIDTH{1'b0}}};   // line aligned
      fm_data    = line;         // victim line read in q2
    end
  end
  assign fm_tq_id = q3_tq_id;

  // a fill never lands on a way already holding its own tag
  evict_tag_a: assert property (@(posedge clk) disable iff (!rst_n)
    (is_fill && q3_dirty_evict) |-> (q3_old_tag != q3_tag));

endmodule

`default_nettype wire

// ==== cache/cache_top.sv ====
// cache top level
// 4-way set-associative lookup pipeline, tag and data arrays included
`timescale 1ns/1ps
`default_nettype none

module cache_top
  import cache_pkg::*;
#(
  parameter int NUM_WAYS = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // lookup request, no back-pressure
  input  logic                   req_valid,
  input  var lu_op_t             req_op,
  input  logic [ADDR_WIDTH-1:0]  req_address,
  input  logic [TQ_ID_WIDTH-1:0] req_tq_id,
  input  logic [WORD_WIDTH-1:0]  req_data,
  input  var cache_line_t        req_cl_data,
  input  logic                   req_fill_modified,
  // lookup response
  output logic                   rsp_valid,
  output lu_op_t                 rsp_op,
  output lu_result_t             rsp_result,
  output logic [TQ_ID_WIDTH-1:0] rsp_tq_id,
  output logic [ADDR_WIDTH-1:0]  rsp_address,
  output cache_line_t            rsp_cl_data,
  // far memory
  output logic                   fm_valid,
  output fm_opcode_t             fm_opcode,
  output logic [ADDR_WIDTH-1:0]  fm_address,
  output logic [TQ_ID_WIDTH-1:0] fm_tq_id,
  output cache_line_t            fm_data
);

  localparam int WAY_WIDTH     = $clog2(NUM_WAYS);
  localparam int CL_ADDR_WIDTH = SET_WIDTH + WAY_WIDTH;   // {set, way}

  // per-set way state held in the tag array
  typedef struct packed {
    logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tags;
    logic [NUM_WAYS-1:0]                valid;
    logic [NUM_WAYS-1:0]                modified;
    logic [NUM_WAYS-1:0]                mru;
  } set_entry_t;

  logic [SET_WIDTH-1:0]     set_rd_addr, set_wr_addr;
  logic                     set_wr_en;
  set_entry_t               set_rd_entry, set_wr_entry;
  logic [CL_ADDR_WIDTH-1:0] cl_rd_addr, cl_wr_addr, q3_data_addr;
  logic                     cl_wr_en;
  cache_line_t              cl_rd_data, cl_wr_data;
  // q3 pipe
  logic                     q3_valid, q3_hit, q3_dirty_evict;
  lu_op_t                   q3_op;
  logic [TAG_WIDTH-1:0]     q3_tag, q3_old_tag;
  logic [SET_WIDTH-1:0]     q3_set;
  logic [OFFSET_WIDTH-1:0]  q3_offset;
  logic [TQ_ID_WIDTH-1:0]   q3_tq_id;
  logic [WORD_WIDTH-1:0]    q3_word;
  cache_line_t              q3_line;

  cache_tag_stage #(.NUM_WAYS(NUM_WAYS)) u_tag_stage (
    .clk, .rst_n,
    .req_valid, .req_op, .req_address, .req_tq_id, .req_data, .req_cl_data,
    .req_fill_modified,
    .set_rd_addr, .set_rd_entry, .set_wr_en, .set_wr_addr, .set_wr_entry,
    .cl_rd_addr,
    .q3_valid, .q3_op, .q3_tag, .q3_set, .q3_offset, .q3_tq_id, .q3_word,
    .q3_line, .q3_hit, .q3_data_addr, .q3_dirty_evict, .q3_old_tag
  );

  cache_data_stage #(.NUM_WAYS(NUM_WAYS)) u_data_stage (
    .clk, .rst_n,
    .q3_valid, .q3_op, .q3_tag, .q3_set, .q3_offset, .q3_tq_id, .q3_word,
    .q3_line, .q3_hit, .q3_data_addr, .q3_dirty_evict, .q3_old_tag,
    .cl_rd_data, .cl_wr_en, .cl_wr_addr, .cl_wr_data,
    .rsp_valid, .rsp_op, .rsp_result, .rsp_tq_id, .rsp_address, .rsp_cl_data,
    .fm_valid, .fm_opcode, .fm_address, .fm_tq_id, .fm_data
  );

  // tag array, one entry per set
  sync_ram #(.DEPTH(NUM_SETS), .entry_t(set_entry_t)) u_tag_array (
    .clk, .rst_n,
    .rd_addr (set_rd_addr),
    .wr_en   (set_wr_en),
    .wr_addr (set_wr_addr),
    .wr_data (set_wr_entry),
    .rd_data (set_rd_entry)
  );

  // data array, one line per set and way
  sync_ram #(.DEPTH(NUM_SETS * NUM_WAYS), .entry_t(cache_line_t)) u_data_array (
    .clk, .rst_n,
    .rd_addr (cl_rd_addr),
    .wr_en   (cl_wr_en),
    .wr_addr (cl_wr_addr),
    .wr_data (cl_wr_data),
    .rd_data (cl_rd_data)
  );

endmodule

`default_nettype wire

// ==== dv/cache_model.svh ====
// cache reference model
// in-order set/way model of the lookup rules plus the response and fm compare tasks
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// one expected q3 output, due two cycles after the request is driven
typedef struct packed {
  int unsigned              due;
  lu_op_t                   op;
  lu_result_t               result;
  logic [TQ_ID_WIDTH-1:0]   tq_id;
  logic [ADDR_WIDTH-1:0]    address;
  cache_line_t              line;
  logic                     fm_valid;
  fm_opcode_t               fm_op;
  logic [ADDR_WIDTH-1:0]    fm_address;
  cache_line_t              fm_data;
} exp_t;

exp_t exp_q[$];

// ============================================================
// model state
// ============================================================
logic [TAG_WIDTH-1:0] m_tag  [NUM_SETS][NUM_WAYS];
cache_line_t          m_line [NUM_SETS][NUM_WAYS];
logic [NUM_WAYS-1:0]  m_valid [NUM_SETS];
logic [NUM_WAYS-1:0]  m_mod   [NUM_SETS];
logic [NUM_WAYS-1:0]  m_mru   [NUM_SETS];

task automatic clear_model;
  for (int s = 0; s < NUM_SETS; s++) begin
    m_valid[s] = '0;
    m_mod[s]   = '0;
    m_mru[s]   = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      m_tag[s][w]  = '0;
      m_line[s][w] = '0;
    end
  end
endtask

// -1 when the tag is not in the set
function automatic int find_way(input logic [SET_WIDTH-1:0] set,
                                input logic [TAG_WIDTH-1:0] tag);
  int way;
  way = -1;
  for (int w = NUM_WAYS - 1; w >= 0; w--) begin
    if (m_valid[set][w] && (m_tag[set][w] == tag)) way = w;
  end
  return way;
endfunction

function automatic int pick_victim(input logic [SET_WIDTH-1:0] set);
  int way;
  way = -1;
  for (int w = NUM_WAYS - 1; w >= 0; w--) begin
    if (!m_valid[set][w]) way = w;   // lowest free way
  end
  if (way < 0) begin
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!m_mru[set][w]) way = w;   // else lowest non-MRU
    end
  end
  return way;
endfunction

// applies one lookup and returns what q3 should show for it
task automatic model_lookup(input lu_op_t op, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [TQ_ID_WIDTH-1:0] tq,
                            input logic [WORD_WIDTH-1:0] data,
                            input cache_line_t fill_line, input logic fill_mod,
                            output exp_t e);
  logic [TAG_WIDTH-1:0]      tag;
  logic [SET_WIDTH-1:0]      set;
  logic [WORD_SEL_WIDTH-1:0] wsel;
  logic [NUM_WAYS-1:0]       touched;
  cache_line_t               tmp;
  int                        hw;
  int                        vw;
  tag     = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  set     = addr[OFFSET_WIDTH +: SET_WIDTH];
  wsel    = addr[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
  touched = '0;
  e         = '0;
  e.op      = op;
  e.tq_id   = tq;
  e.address = addr;
  hw = find_way(set, tag);
  if (op == FILL_LU) begin
    vw       = pick_victim(set);
    e.result = FILL;
    e.line   = fill_line;
    if (m_valid[set][vw] && m_mod[set][vw]) begin   // modified victim goes back
      e.fm_valid   = 1'b1;
      e.fm_op      = DIRTY_EVICT_OP;
      e.fm_address = {m_tag[set][vw], set, {OFFSET_WIDTH{1'b0}}};
      e.fm_data    = m_line[set][vw];
    end
    m_tag[set][vw]   = tag;
    m_line[set][vw]  = fill_line;
    m_valid[set][vw] = 1'b1;
    m_mod[set][vw]   = fill_mod;
    touched[vw]      = 1'b1;
  end else if (hw >= 0) begin
    e.result    = HIT;
    touched[hw] = 1'b1;
    if (op == WR_LU) begin
      tmp             = m_line[set][hw];
      tmp[wsel]       = data;           // single word merge
      m_line[set][hw] = tmp;
      m_mod[set][hw]  = 1'b1;
    end else begin
      e.line = m_line[set][hw];
    end
  end else begin
    e.result     = MISS;                // rd or wr miss fetches the line
    e.fm_valid   = 1'b1;
    e.fm_op      = FILL_REQ_OP;
    e.fm_address = addr;
  end
  m_mru[set] = m_mru[set] | touched;
  if ((|touched) && (&m_mru[set])) m_mru[set] = touched;   // MRU wrap
endtask

// ============================================================
// compare tasks
// ============================================================
task automatic report_error(input string msg);
  $display("[ERROR] %0t ns: %s", $time, msg);
  fail_run();
endtask

task automatic check_rsp(input logic exp_valid, input lu_op_t exp_op,
                         input lu_result_t exp_res, input logic [TQ_ID_WIDTH-1:0] exp_tq,
                         input logic [ADDR_WIDTH-1:0] exp_addr, input cache_line_t exp_line);
  if (rsp_valid !== exp_valid)
    report_error($sformatf("rsp_valid got %b expected %b", rsp_valid, exp_valid));
  else if (exp_valid && (rsp_op !== exp_op))
    report_error($sformatf("rsp_op got %0d expected %0d", rsp_op, exp_op));
  else if (exp_valid && (rsp_result !== exp_res))
    report_error($sformatf("rsp_result got %0d expected %0d", rsp_result, exp_res));
  else if (exp_valid && (rsp_tq_id !== exp_tq))
    report_error($sformatf("rsp_tq_id got %h expected %h", rsp_tq_id, exp_tq));
  else if (exp_valid && (rsp_address !== exp_addr))
    report_error($sformatf("rsp_address got %h expected %h", rsp_address, exp_addr));
  else if (exp_valid && (rsp_cl_data !== exp_line))
    report_error($sformatf("rsp_cl_data got %h expected %h", rsp_cl_data, exp_line));
endtask

task automatic check_fm(input logic exp_valid, input fm_opcode_t exp_op,
                        input logic [ADDR_WIDTH-1:0] exp_addr,
                        input logic [TQ_ID_WIDTH-1:0] exp_tq, input cache_line_t exp_data);
  if (fm_valid !== exp_valid)
    report_error($sformatf("fm_valid got %b expected %b", fm_valid, exp_valid));
  else if (exp_valid && (fm_opcode !== exp_op))
    report_error($sformatf("fm_opcode got %0d expected %0d", fm_opcode, exp_op));
  else if (exp_valid && (fm_address !== exp_addr))
    report_error($sformatf("fm_address got %h expected %h", fm_address, exp_addr));
  else if (exp_valid && (fm_tq_id !== exp_tq))
    report_error($sformatf("fm_tq_id got %h expected %h", fm_tq_id, exp_tq));
  else if (exp_valid && (fm_data !== exp_data))
    report_error($sformatf("fm_data got %h expected %h", fm_data, exp_data));
endtask

`endif

// ==== dv/cache_tb.sv ====
// cache testbench
// directed and seeded random lookups checked against an in-order model at 2-cycle latency
`timescale 1ns/1ps
`default_nettype none

module cache_tb
  import cache_pkg::*;
;

  localparam int NUM_WAYS        = 4;
  localparam int SEED            = 41783;
  localparam int RAND_OPS        = 2000;
  localparam int DIRECTED_CYCLES = 60;
  localparam int STIM_CYCLES     = DIRECTED_CYCLES + 4 * RAND_OPS;   // gap of 3 at most
  localparam int TIMEOUT_CYCLES  = 2 * STIM_CYCLES + 100;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid;
  lu_op_t                 req_op;
  logic [ADDR_WIDTH-1:0]  req_address;
  logic [TQ_ID_WIDTH-1:0] req_tq_id;
  logic [WORD_WIDTH-1:0]  req_data;
  cache_line_t            req_cl_data;
  logic                   req_fill_modified;
  logic                   rsp_valid;
  lu_op_t                 rsp_op;
  lu_result_t             rsp_result;
  logic [TQ_ID_WIDTH-1:0] rsp_tq_id;
  logic [ADDR_WIDTH-1:0]  rsp_address;
  cache_line_t            rsp_cl_data;
  logic                   fm_valid;
  fm_opcode_t             fm_opcode;
  logic [ADDR_WIDTH-1:0]  fm_address;
  logic [TQ_ID_WIDTH-1:0] fm_tq_id;
  cache_line_t            fm_data;

  int unsigned cycle_cnt;
  int unsigned n_checked;

  task automatic fail_run;
    $display("Result: FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  `include "cache_model.svh"

  cache_top #(.NUM_WAYS(NUM_WAYS)) dut (
    .clk, .rst_n,
    .req_valid, .req_op, .req_address, .req_tq_id, .req_data, .req_cl_data,
    .req_fill_modified,
    .rsp_valid, .rsp_op, .rsp_result, .rsp_tq_id, .rsp_address, .rsp_cl_data,
    .fm_valid, .fm_opcode, .fm_address, .fm_tq_id, .fm_data
  );

  // ============================================================
  // clock, cycle count, timeout
  // ============================================================
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  initial cycle_cnt = 0;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      fail_run();
    end
  end

  // q3 outputs are all registered and settled by mid-cycle
  always @(negedge clk) begin : check_outputs
    exp_t e;
    if (rst_n) begin
      if ((exp_q.size() > 0) && (exp_q[0].due == cycle_cnt)) begin
        e = exp_q.pop_front();
        check_rsp(1'b1, e.op, e.result, e.tq_id, e.address, e.line);
        check_fm(e.fm_valid, e.fm_op, e.fm_address, e.tq_id, e.fm_data);
        n_checked++;
      end else begin
        check_rsp(1'b0, RD_LU, NO_RSP, '0, '0, '0);   // nothing due this cycle
        check_fm(1'b0, FILL_REQ_OP, '0, '0, '0);
      end
    end
  end

  // ============================================================
  // stimulus helpers
  // ============================================================
  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    req_valid = 1'b0;
    repeat (n) next_cycle();
  endtask

  function automatic cache_line_t rand_line;
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
                                                      input logic [SET_WIDTH-1:0] set,
                                                      input logic [1:0] word);
    return {tag, set, word, 2'b00};
  endfunction

  // drive one lookup and queue what should come out 2 cycles later
  task automatic issue(input lu_op_t op, input logic [ADDR_WIDTH-1:0] addr,
                       input logic [TQ_ID_WIDTH-1:0] tq, input logic [WORD_WIDTH-1:0] data,
                       input cache_line_t line, input logic fill_mod);
    exp_t e;
    req_valid         = 1'b1;
    req_op            = op;
    req_address       = addr;
    req_tq_id         = tq;
    req_data          = data;
    req_cl_data       = line;
    req_fill_modified = fill_mod;
    model_lookup(op, addr, tq, data, line, fill_mod, e);
    e.due = cycle_cnt + 2;
    exp_q.push_back(e);
    next_cycle();
    req_valid = 1'b0;
  endtask

  task automatic random_mix(input int n_ops);
    logic [SET_WIDTH-1:0]  set;
    logic [TAG_WIDTH-1:0]  tag;
    logic [ADDR_WIDTH-1:0] addr;
    logic [1:0]            lo;
    lu_op_t                op;
    int unsigned           r;
    for (int i = 0; i < n_ops; i++) begin
      set  = ($urandom % 2) ? 4'd3 : 4'd12;   // two sets and six tags force evictions
      tag  = 12'h0a0 + ($urandom % 6);
      lo   = $urandom % 4;
      addr = make_addr(tag, set, $urandom % 4) | lo;
      r    = $urandom % 10;
      op   = (r < 4) ? RD_LU : ((r < 7) ? WR_LU : FILL_LU);
      if ((op == FILL_LU) && (find_way(set, tag) >= 0)) op = RD_LU;   // no double fill
      issue(op, addr, $urandom, $urandom, rand_line(), $urandom % 2);
      if (($urandom % 5) == 0) idle(1 + ($urandom % 3));
    end
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    logic [ADDR_WIDTH-1:0] a;
    void'($urandom(SEED));
    n_checked         = 0;
    rst_n             = 1'b0;
    req_valid         = 1'b0;
    req_op            = RD_LU;
    req_address       = '0;
    req_tq_id         = '0;
    req_data          = '0;
    req_cl_data       = '0;
    req_fill_modified = 1'b0;
    clear_model();
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    idle(5);                                      // outputs stay low
    issue(RD_LU, make_addr(12'h3c7, 4'h9, 2'd1) | 2'd2, 4'h7, '0, '0, 1'b0);

    // fill then back-to-back read exercises set and data forwarding
    a = make_addr(12'h011, 4'h1, 2'd2);
    issue(FILL_LU, a, 4'h1, '0, rand_line(), 1'b0);
    issue(RD_LU, a, 4'h2, '0, '0, 1'b0);

    // write hit merge read back back-to-back and after a gap
    issue(WR_LU, a, 4'h3, 32'hcafe_0123, '0, 1'b0);
    issue(RD_LU, a, 4'h4, '0, '0, 1'b0);
    idle(3);
    issue(RD_LU, make_addr(12'h011, 4'h1, 2'd0), 4'h5, '0, '0, 1'b0);
    idle(2);

    // six fills into set 5 where the fifth evicts modified way 0 and the sixth a clean way
    for (int i = 0; i < 6; i++) begin
      issue(FILL_LU, make_addr(12'h100 + i, 4'h5, 2'd0), i, '0, rand_line(), i == 0);
    end
    idle(3);

    random_mix(RAND_OPS);
    idle(4);

    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      fail_run();
    end else begin
      $display("%0d lookups checked", n_checked);
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+dv
common/cache_pkg.sv
hdl/sync_ram.sv
cache/cache_victim_sel.sv
cache/cache_tag_stage.sv
cache/cache_data_stage.sv
cache/cache_top.sv
dv/cache_tb.sv
